// ==== spi_stim.txt ====
# command (hex), expected read data (hex, 00 for writes), stray command (hex)
# strobed mid-frame while the master is busy, 000 when there is none
000 A0 000
500 A5 000
700 A7 000
83C 00 000
000 3C 000
9E1 00 000
D5A 00 000
000 3C 000
100 E1 000
500 5A 000
A96 00 FFF
200 96 000
700 A7 000
300 A3 BC4
300 A3 000
BFF 00 000
C00 00 000
400 00 000
300 FF 000
600 A6 000
E81 00 000
600 81 000
F55 00 000
700 55 000
200 96 000
100 E1 000

// ==== sources.f ====
spi_pkg.sv
spi_shift_reg.sv
spi_sequencer.sv
spi_master_top.sv
spi_slave_model.sv
spi_master_checker.sv
tb_spi_master.sv

// ==== Bender.yml ====
package:
  name: spi_master

sources:
  - spi_pkg.sv
  - spi_shift_reg.sv
  - spi_sequencer.sv
  - spi_master_top.sv
  - target: simulation
    files:
      - spi_slave_model.sv
      - spi_master_checker.sv
      - tb_spi_master.sv

// ==== tb_spi_master.sv ====
`default_nettype none

module tb_spi_master;

  timeunit 1ns;
  timeprecision 100ps;

  import spi_pkg::*;

  logic        clk;
  logic        rst_n;
  cmd_t        cmd_in;
  logic        cmd_vld;
  logic        miso;
  logic        cmd_rdy;
  logic        sclk;
  logic        cs;
  logic        mosi;
  logic        read_vld;
  rdata_t      read_data;

  cmd_t        cmd_q[$];
  rdata_t      exp_q[$];
  cmd_t        stray_q[$];
  int          n_cmds;
  int          errors;
  int          checks;
  int          reads_sent;
  int          vld_pulses;
  int unsigned lcg_state;
  bit          stim_ok;

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  spi_master_top spi_master_top_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .miso      (miso),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_slave_model slave_inst (
    .sclk (sclk),
    .cs   (cs),
    .mosi (mosi),
    .miso (miso)
  );

  bind spi_master_top spi_master_checker checker_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .sclk     (sclk),
    .cs       (cs),
    .cmd_rdy  (cmd_rdy),
    .read_vld (read_vld)
  );

  function automatic int unsigned next_gap();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return (lcg_state >> 16) & 32'hF;    // 0 to 15 idle cycles
  endfunction

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERR %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_rdata(input string name, input rdata_t got, input rdata_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERR %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp)
    begin
      errors++;
      $display("ERR %s: got %0h, expected %0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic load_stim(output bit ok);
    int     fd;
    string  line;
    cmd_t   c;
    rdata_t e;
    cmd_t   s;
    ok = 1'b0;
    fd = $fopen("spi_stim.txt", "r");
    if (fd != 0)
    begin
      while ($fgets(line, fd) > 0)
      begin
        if (line.substr(0, 0) != "#" && $sscanf(line, "%h %h %h", c, e, s) == 3)
        begin
          cmd_q.push_back(c);
          exp_q.push_back(e);
          stray_q.push_back(s);
        end
      end
      $fclose(fd);
      ok = (cmd_q.size() > 0);
    end
    n_cmds = cmd_q.size();
  endtask

  // counts clk cycles (at falling clk) while cs holds the given level
  task automatic measure_cs(input logic level, output int cycles);
    cycles = 0;
    while (cs === level)
    begin
      cycles++;
      @(negedge clk);
    end
  endtask

  task automatic strobe_stray(input cmd_t stray);
    if (stray != '0)
    begin
      repeat (20) @(posedge clk);
      cmd_in  <= stray;
      cmd_vld <= 1'b1;
      @(negedge clk);
      check_flag("cmd_rdy", cmd_rdy, 1'b0);   // must be ignored
      @(posedge clk);
      cmd_vld <= 1'b0;
    end
  endtask

  task automatic run_command(input cmd_t cmd, input rdata_t exp, input cmd_t stray);
    int   gap;
    int   low_a;
    int   high_b;
    int   low_c;
    logic is_write;
    is_write = cmd[WRITE_BIT];
    gap      = next_gap();
    while (cmd_rdy !== 1'b1)
    begin
      @(negedge clk);
    end
    repeat (gap) @(posedge clk);
    @(posedge clk);
    cmd_in  <= cmd;
    cmd_vld <= 1'b1;
    @(posedge clk);    // accepting edge
    cmd_vld <= 1'b0;
    @(negedge clk);
    fork
      measure_cs(1'b0, low_a);
      strobe_stray(stray);
    join
    if (is_write)
    begin
      check_count("cs low cycles", low_a, CMD_W * 2 * HALF_PERIOD);
    end
    else
    begin
      check_count("cs low cycles, address frame", low_a, ADDR_PHASE_BITS * 2 * HALF_PERIOD);
      measure_cs(1'b1, high_b);
      check_count("cs high cycles, read gap", high_b, READ_GAP);
      measure_cs(1'b0, low_c);
      check_count("cs low cycles, data frame", low_c, RDATA_W * 2 * HALF_PERIOD);
      reads_sent++;
    end
    check_flag("cmd_rdy", cmd_rdy, 1'b0);
    check_flag("read_vld", read_vld, 1'b0);
    @(negedge clk);
    check_flag("cmd_rdy", cmd_rdy, 1'b1);
    check_flag("read_vld", read_vld, !is_write);
    if (!is_write)
    begin
      check_rdata("read_data", read_data, exp);
    end
    @(negedge clk);
    check_flag("read_vld", read_vld, 1'b0);
  endtask

  always @(negedge clk)
  begin
    if (rst_n && read_vld === 1'b1)
    begin
      vld_pulses++;
    end
  end

  initial
  begin
    wait (n_cmds > 0);
    repeat (n_cmds * 300 + 10) @(posedge clk);
    $display("timeout: the master stopped finishing commands");
    $display("*** FAILED ***");
    $finish;
  end

  initial
  begin
    rst_n      = 1'b0;
    cmd_in     = '0;
    cmd_vld    = 1'b0;
    errors     = 0;
    checks     = 0;
    reads_sent = 0;
    vld_pulses = 0;
    lcg_state  = 26;
    load_stim(stim_ok);
    if (!stim_ok)
    begin
      $display("no commands could be read from spi_stim.txt");
      $display("*** FAILED ***");
      $finish;
    end
    else
    begin
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_flag("cmd_rdy", cmd_rdy, 1'b1);
      check_flag("cs", cs, 1'b1);
      check_flag("sclk", sclk, 1'b0);
      check_flag("mosi", mosi, 1'b0);
      check_flag("read_vld", read_vld, 1'b0);
      foreach (cmd_q[i])
      begin
        run_command(cmd_q[i], exp_q[i], stray_q[i]);
      end
      repeat (4) @(negedge clk);
      check_count("read_vld pulses", vld_pulses, reads_sent);
      check_count("assertion failures", spi_master_top_inst.checker_inst.fail_count, 0);
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
      begin
        $display("*** PASSED ***");
      end
      else
      begin
        $display("*** FAILED ***");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== spi_master_checker.sv ====
`default_nettype none

module spi_master_checker (
  input logic clk,
  input logic rst_n,
  input logic sclk,
  input logic cs,
  input logic cmd_rdy,
  input logic read_vld
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_count = 0;

  // mode 0 keeps sclk parked low outside a frame
  sclk_idle_a: assert property (@(posedge clk) disable iff (!rst_n) cs |-> !sclk)
  else
  begin
    $error("sclk high while cs is high");
    fail_count++;
  end

  busy_a: assert property (@(posedge clk) disable iff (!rst_n) !cs |-> !cmd_rdy)
  else
  begin
    $error("cmd_rdy high during a frame");
    fail_count++;
  end

  rvld_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld |-> cmd_rdy ##1 !read_vld)
  else
  begin
    $error("read_vld longer than one cycle or without cmd_rdy");
    fail_count++;
  end

endmodule

`default_nettype wire

// ==== spi_slave_model.sv ====
`default_nettype none

module spi_slave_model (
  input  logic sclk,
  input  logic cs,
  input  logic mosi,
  output logic miso
);

  timeunit 1ns;
  timeprecision 100ps;

  import spi_pkg::*;

  rdata_t regs [2**ADDR_W];
  cmd_t   rx_sr;
  int     rx_bits;
  addr_t  rd_addr;
  logic   rd_pending;       // address frame seen so the data frame is next
  rdata_t tx_sr;

  initial
  begin
    for (int i = 0; i < 2**ADDR_W; i++)
    begin
      regs[i] = rdata_t'(8'hA0 + i);
    end
    rx_sr      = '0;
    rx_bits    = 0;
    rd_addr    = '0;
    rd_pending = 1'b0;
    tx_sr      = '0;
  end

  assign miso = tx_sr[RDATA_W-1];

  // mode 0 sample point
  always @(posedge sclk)
  begin
    if (!cs)
    begin
      rx_sr   <= {rx_sr[CMD_W-2:0], mosi};
      rx_bits <= rx_bits + 1;
    end
  end

  // at frame end the bit count tells what the frame was
  always @(posedge cs)
  begin
    if (rx_bits == CMD_W && rx_sr[WRITE_BIT])
    begin
      regs[rx_sr[WRITE_BIT-1 -: ADDR_W]] <= rx_sr[RDATA_W-1:0];
    end
    else if (rx_bits == ADDR_PHASE_BITS && !rx_sr[ADDR_PHASE_BITS-1])
    begin
      rd_addr    <= rx_sr[ADDR_W-1:0];
      rd_pending <= 1'b1;
    end
    else
    begin
      rd_pending <= 1'b0;
    end
    rx_bits <= 0;
  end

  always @(negedge cs)
  begin
    tx_sr <= rd_pending ? regs[rd_addr] : '0;   // first bit out right away
  end

  always @(negedge sclk)
  begin
    if (!cs)
    begin
      tx_sr <= tx_sr << 1;
    end
  end

endmodule

`default_nettype wire

// ==== spi_master_top.sv ====
`default_nettype none

module spi_master_top (
  input  logic            clk,
  input  logic            rst_n,
  input  spi_pkg::cmd_t   cmd_in,
  input  logic            cmd_vld,
  input  logic            miso,
  output logic            cmd_rdy,
  output logic            sclk,
  output logic            cs,         // active low
  output logic            mosi,
  output logic            read_vld,
  output spi_pkg::rdata_t read_data
);

  import spi_pkg::*;

  logic tx_load;
  logic tx_shift;
  logic rx_shift;

  spi_sequencer seq_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_vld    (cmd_vld),
    .write_flag (cmd_in[WRITE_BIT]),  // only looked at on acceptance
    .cmd_rdy    (cmd_rdy),
    .sclk       (sclk),
    .cs         (cs),
    .tx_load    (tx_load),
    .tx_shift   (tx_shift),
    .rx_shift   (rx_shift),
    .read_vld   (read_vld)
  );

  // command out on mosi with zeros filling from below
  spi_shift_reg #(
    .payload_t (cmd_t)
  ) tx_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .load       (tx_load),
    .load_value (cmd_in),
    .shift      (tx_shift),
    .serial_in  (1'b0),
    .serial_out (mosi),
    .value      ()
  );

  // read data in from miso and never loaded
  spi_shift_reg #(
    .payload_t (rdata_t)
  ) rx_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .load       (1'b0),
    .load_value ('0),
    .shift      (rx_shift),
    .serial_in  (miso),
    .serial_out (),
    .value      (read_data)
  );

endmodule

`default_nettype wire

// ==== spi_sequencer.sv ====
`default_nettype none

module spi_sequencer (
  input  logic clk,
  input  logic rst_n,
  input  logic cmd_vld,
  input  logic write_flag,
  output logic cmd_rdy,
  output logic sclk,
  output logic cs,
  output logic tx_load,
  output logic tx_shift,
  output logic rx_shift,
  output logic read_vld
);

  import spi_pkg::*;

  seq_state_t           state;
  logic [HP_CNT_W-1:0]  hp_cnt;
  logic [BIT_CNT_W-1:0] bit_cnt;
  logic [GAP_CNT_W-1:0] gap_cnt;
  logic                 is_wr;     // command type latched at acceptance

  logic                 accept;
  logic                 in_frame;
  logic                 half_done;
  logic                 bit_done;
  logic                 last_bit;
  logic                 frame_end;
  logic                 gap_done;

  // handshake
  assign cmd_rdy = (state == ST_IDLE);
  assign accept  = cmd_vld & cmd_rdy;
  assign tx_load = accept;            // command sits in the tx register before the first bit

  assign in_frame = (state == ST_WRITE) || (state == ST_RADDR) || (state == ST_RDATA);

  // half_done marks the clk edge where sclk toggles
  assign half_done = in_frame && (hp_cnt == HP_CNT_W'(HALF_PERIOD - 1));
  assign bit_done  = half_done & sclk;    // falling sclk ends a bit
  assign frame_end = bit_done & last_bit;
  assign gap_done  = (gap_cnt == GAP_CNT_W'(READ_GAP - 1));

  // mosi moves on falling sclk and miso is taken on rising sclk
  assign tx_shift = bit_done & ((state == ST_WRITE) || (state == ST_RADDR));
  assign rx_shift = half_done & ~sclk & (state == ST_RDATA);

  // frame length depends on which frame is running
  always_comb
  begin
    case (state)
      ST_WRITE: last_bit = (bit_cnt == BIT_CNT_W'(CMD_W - 1));
      ST_RADDR: last_bit = (bit_cnt == BIT_CNT_W'(ADDR_PHASE_BITS - 1));
      ST_RDATA: last_bit = (bit_cnt == BIT_CNT_W'(RDATA_W - 1));
      default:  last_bit = 1'b0;
    endcase
  end

  // sclk generator that idles low outside a frame (mode 0)
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      hp_cnt <= '0;
      sclk   <= 1'b0;
    end
    else if (!in_frame)
    begin
      hp_cnt <= '0;
      sclk   <= 1'b0;
    end
    else if (half_done)
    begin
      hp_cnt <= '0;
      sclk   <= ~sclk;
    end
    else
    begin
      hp_cnt <= hp_cnt + 1'b1;
    end
  end

  // bits done in the current frame
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bit_cnt <= '0;
    end
    else if (!in_frame)
    begin
      bit_cnt <= '0;
    end
    else if (bit_done)
    begin
      bit_cnt <= last_bit ? '0 : bit_cnt + 1'b1;
    end
  end

  // cs high time between the two read frames
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      gap_cnt <= '0;
    end
    else if (state != ST_RGAP)
    begin
      gap_cnt <= '0;
    end
    else
    begin
      gap_cnt <= gap_cnt + 1'b1;
    end
  end

  // frame FSM with cs registered alongside the state
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= ST_IDLE;
      cs       <= 1'b1;
      is_wr    <= 1'b0;
      read_vld <= 1'b0;
    end
    else
    begin
      // one pulse as the sequencer drops back to idle after a read
      read_vld <= (state == ST_FINISH) & ~is_wr;

      case (state)
        ST_IDLE:
        begin
          if (accept)
          begin
            is_wr <= write_flag;
            cs    <= 1'b0;
            state <= write_flag ? ST_WRITE : ST_RADDR;
          end
        end
        ST_WRITE:
        begin
          if (frame_end)
          begin
            cs    <= 1'b1;
            state <= ST_FINISH;
          end
        end
        ST_RADDR:
        begin
          if (frame_end)
          begin
            cs    <= 1'b1;
            state <= ST_RGAP;
          end
        end
        ST_RGAP:
        begin
          if (gap_done)
          begin
            cs    <= 1'b0;  // slave puts its first bit out here
            state <= ST_RDATA;
          end
        end
        ST_RDATA:
        begin
          if (frame_end)
          begin
            cs    <= 1'b1;
            state <= ST_FINISH;
          end
        end
        ST_FINISH:
        begin
          state <= ST_IDLE;
        end
        default:
        begin
          cs    <= 1'b1;
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== spi_shift_reg.sv ====
`default_nettype none

module spi_shift_reg #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     load,
  input  payload_t load_value,
  input  logic     shift,
  input  logic     serial_in,
  output logic     serial_out,
  output payload_t value
);

  payload_t shreg;

  // load wins over shift
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      shreg <= '0;  // keeps mosi low out of reset
    end
    else if (load)
    begin
      shreg <= load_value;
    end
    else if (shift)
    begin
      // msb leaves and a new bit enters at the bottom
      shreg <= (shreg << 1) | payload_t'(serial_in);
    end
  end

  assign serial_out = shreg[$bits(payload_t)-1];
  assign value      = shreg;

endmodule

`default_nettype wire

// ==== spi_pkg.sv ====
`default_nettype none

package spi_pkg;

  // command and data widths
  localparam int CMD_W           = 12;
  localparam int RDATA_W         = 8;
  localparam int ADDR_W          = 3;
  localparam int ADDR_PHASE_BITS = 4;   // write flag plus address
  localparam int WRITE_BIT       = 11;

  // timing in clk cycles
  localparam int HALF_PERIOD = 4;       // sclk half period
  localparam int READ_GAP    = 100;     // cs high between address and data frame

  // counter widths derived from the above
  localparam int HP_CNT_W  = $clog2(HALF_PERIOD);
  localparam int BIT_CNT_W = $clog2(CMD_W);
  localparam int GAP_CNT_W = $clog2(READ_GAP);

  typedef logic [CMD_W-1:0]   cmd_t;
  typedef logic [RDATA_W-1:0] rdata_t;
  typedef logic [ADDR_W-1:0]  addr_t;

  // frame sequencer states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WRITE,
    ST_RADDR,
    ST_RGAP,
    ST_RDATA,
    ST_FINISH
  } seq_state_t;

endpackage

`default_nettype wire
